// File: bench/clock_gen.sv
// clock_gen: free running bench clock and synchronous reset pulse
`timescale 1ns/1ps

module clock_gen #(
    parameter int half_period  = 2,  // 4 ns period
    parameter int reset_cycles = 16
) (
    output logic clock,
    output logic reset
);
    initial begin
        clock = 1'b0;
        forever #(half_period) clock = ~clock;
    end

    // high across reset_cycles rising edges, dropped between edges
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
    end

endmodule

// File: bench/core_properties.sv
// occupancy and pop rules, bound to reorder_buffer and free_list
`timescale 1ns/1ps

module core_properties (
    input logic clock,
    input logic reset,
    input int   count,   // entries in use
    input int   limit,   // structure size
    input logic pop,     // retire or alloc
    input logic pop_ok   // entry may leave
);
    // never more entries than slots
    occupancy_bound: assert property (@(posedge clock) disable iff (reset)
        count <= limit)
        else $error("occupancy %0d above size %0d", count, limit);

    // a retired rob entry had its result
    // an alloc finds a tag on offer
    pop_when_ready: assert property (@(posedge clock) disable iff (reset)
        pop |-> pop_ok)
        else $error("pop while the entry is not ready");

endmodule

//////////////////////////////////////////////////////////////////////
// attach to rob and free list
//////////////////////////////////////////////////////////////////////

// retire pulse is one edge late, the retired entry sits just behind head
bind reorder_buffer core_properties rob_props (
    .clock(clock), .reset(reset), .count(int'(count)), .limit(rob_depth),
    .pop(retire_valid), .pop_ok(complete[head - 1'b1])
);

bind free_list core_properties fl_props (
    .clock(clock), .reset(reset), .count(int'(count)), .limit(fl_size),
    .pop(alloc), .pop_ok(free_valid)
);

// File: bench/core_tb.sv
// stimulus table, golden register model, retirement checks, watchdog
`timescale 1ns/1ps

module core_tb;
    import core_pkg::*;

    logic      clock, reset;
    logic      inst_valid;
    inst_t     inst;
    logic      inst_stall;
    logic      retire_valid;
    arch_reg_t retire_rd;
    word_t     retire_value;

    // stimulus table (gap -1 draws an lfsr gap)
    string     row_name [$];
    int        row_gap  [$];
    inst_t     row_inst [$];

    // expected retirements in program order
    string     exp_name [$];
    arch_reg_t exp_rd   [$];
    word_t     exp_val  [$];

    word_t       gold [arch_regs];  // architectural state of the model
    logic [31:0] lfsr = 32'h2ecd;

    clock_gen clk_0 (.clock(clock), .reset(reset));

    core_top #(.pr_count(48), .rob_depth(8)) UUT (
        .clock(clock), .reset(reset),
        .inst_valid(inst_valid), .inst(inst), .inst_stall(inst_stall),
        .retire_valid(retire_valid), .retire_rd(retire_rd), .retire_value(retire_value)
    );

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // two lfsr bits -> 0..3 idle cycles
    task automatic random_gap(output int gap);
        gap = 0;
        repeat (2) begin
            gap  = (gap << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic word_t alu_model(input alu_op_t op, input word_t a, input word_t b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_sll:  return a << b[4:0];
            default: return '0;
        endcase
    endfunction

    task automatic add_row(input string name, input int gap, input alu_op_t op,
                           input int rd, input int rs1, input int rs2,
                           input word_t imm, input logic use_imm);
        inst_t i;
        i.op      = op;
        i.rd      = arch_reg_t'(rd);
        i.rs1     = arch_reg_t'(rs1);
        i.rs2     = arch_reg_t'(rs2);
        i.imm     = imm;
        i.use_imm = use_imm;
        row_name.push_back(name);
        row_gap.push_back(gap);
        row_inst.push_back(i);
    endtask

    task automatic build_table();
        // one of each op with an immediate second operand
        add_row("imm_ops", 0, op_add, 1, 0, 0, 32'h1234_5678, 1'b1);
        add_row("imm_ops", 0, op_sub, 2, 0, 0, 32'h0000_0005, 1'b1);
        add_row("imm_ops", 0, op_xor, 3, 0, 0, 32'hdead_beef, 1'b1);
        add_row("imm_ops", 0, op_or,  4, 0, 0, 32'h00f0_0f00, 1'b1);
        add_row("imm_ops", 2, op_and, 5, 1, 0, 32'h0ff0_0ff0, 1'b1);
        add_row("imm_ops", 2, op_sll, 6, 3, 0, 32'h0000_0024, 1'b1); // upper imm bits ignored
        // back to back chain reading the previous rd
        add_row("dep_chain", 0, op_add, 7,  1,  2,  '0, 1'b0);
        add_row("dep_chain", 0, op_sub, 8,  7,  3,  '0, 1'b0);
        add_row("dep_chain", 0, op_xor, 9,  8,  8,  '0, 1'b0);
        add_row("dep_chain", 0, op_and, 10, 9,  4,  '0, 1'b0);
        add_row("dep_chain", 0, op_or,  11, 10, 6,  '0, 1'b0);
        add_row("dep_chain", 0, op_sll, 12, 11, 5,  '0, 1'b0);
        add_row("dep_chain", 0, op_add, 7,  12, 7,  '0, 1'b0);
        // r0 as destination and source
        add_row("r0_write", 0, op_add, 0,  1, 0, 32'h0000_0007, 1'b1);
        add_row("r0_write", 0, op_add, 13, 0, 2, '0, 1'b0);
        add_row("r0_write", 0, op_or,  0,  0, 0, '0, 1'b0);
        add_row("r0_write", 0, op_sub, 14, 0, 0, 32'h0000_0001, 1'b1);
        // more writes than spare tags
        for (int k = 0; k < 60; k++) begin
            add_row("tag_recycle", 0, alu_op_t'(k % 6), 1 + k % 31, k % 31, (7 * k) % 32,
                    word_t'(32'h0101_0101 * k), k[0]);
        end
        for (int k = 0; k < 20; k++) begin
            add_row("random_gap", -1, alu_op_t'((5 * k) % 6), (5 * k) % 32, (3 * k) % 32,
                    (11 * k) % 32, word_t'(32'h3c5a_0000 + k), k[1]);
        end
    endtask

    // run the row through the model and queue its retirement
    task automatic predict(input int r);
        inst_t i;
        word_t a, b, v;
        i = row_inst[r];
        a = gold[i.rs1];
        b = i.use_imm ? i.imm : gold[i.rs2];
        v = (i.rd == 0) ? '0 : alu_model(i.op, a, b);
        if (i.rd != 0) begin
            gold[i.rd] = v;
        end
        exp_name.push_back(row_name[r]);
        exp_rd.push_back(i.rd);
        exp_val.push_back(v);
    endtask

    // hold until a rising edge sees inst_stall low
    task automatic send_inst(input inst_t i);
        inst_valid = 1'b1;
        inst       = i;
        while (inst_stall) begin
            @(negedge clock);
        end
        @(negedge clock);   // taken at the edge just passed
        inst_valid = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int gap;
        inst_valid = 1'b0;
        inst       = '0;
        foreach (gold[i]) gold[i] = '0;
        build_table();
        @(negedge clock);   // reset is driven by now
        while (reset) begin
            @(negedge clock);
        end
        assert (retire_valid == 1'b0)
            else abort_run($sformatf("[ERROR] after_reset retire_valid expected 0 actual %0d",
                                     retire_valid));
        assert (inst_stall == 1'b0)
            else abort_run($sformatf("[ERROR] after_reset inst_stall expected 0 actual %0d",
                                     inst_stall));
        for (int r = 0; r < row_inst.size(); r++) begin
            gap = row_gap[r];
            if (gap < 0) begin
                random_gap(gap);
            end
            repeat (gap) @(negedge clock);
            predict(r);
            send_inst(row_inst[r]);
        end
        while (exp_rd.size() != 0) begin
            @(negedge clock);
        end
        repeat (8) @(negedge clock);   // stray retirements abort in the monitor
        $display("NO ERRORS");
        $finish;
    end

    // retire outputs are registered and stable across the low phase
    initial begin
        forever begin
            @(negedge clock);
            if (!reset && retire_valid) begin
                if (exp_rd.size() == 0) begin
                    abort_run("retirement seen with no instruction outstanding");
                end else begin
                    assert (retire_rd == exp_rd[0])
                        else abort_run($sformatf("[ERROR] %s rd expected %0d actual %0d",
                                                 exp_name[0], exp_rd[0], retire_rd));
                    assert (retire_value == exp_val[0])
                        else abort_run($sformatf("[ERROR] %s value expected %h actual %h",
                                                 exp_name[0], exp_val[0], retire_value));
                    void'(exp_name.pop_front());
                    void'(exp_rd.pop_front());
                    void'(exp_val.pop_front());
                end
            end
        end
    end

    // watchdog allows 20 cycles a row plus reset
    initial begin
        int limit;
        #1;
        limit = 20 * row_inst.size() + 16;
        repeat (limit) @(posedge clock);
        abort_run($sformatf("timeout: run did not finish within %0d cycles", limit));
    end

endmodule

// File: files.f
src/core_pkg.sv
src/cdb_if.sv
src/inst_buffer.sv
src/rename_stage.sv
src/free_list.sv
src/reorder_buffer.sv
src/issue_stage.sv
src/alu_stage.sv
src/core_top.sv
bench/clock_gen.sv
bench/core_properties.sv
bench/core_tb.sv

// File: run.sh
#!/bin/sh
# build the core testbench with verilator, run it, judge by the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module core_tb -f files.f

./obj_dir/Vcore_tb | tee sim.log

if grep -q "^NO ERRORS$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: src/alu_stage.sv
// alu_stage: alu operation and registered result broadcast
`timescale 1ns/1ps

module alu_stage #(
    parameter int pr_count  = 48,
    parameter int rob_depth = 8
) (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         exec_valid,
    input  core_pkg::alu_op_t            exec_op,
    input  core_pkg::word_t              exec_a,
    input  core_pkg::word_t              exec_b,
    input  logic [$clog2(pr_count)-1:0]  exec_tag,
    input  logic [$clog2(rob_depth)-1:0] exec_rob_idx,
    cdb_if.source                        cdb
);
    import core_pkg::*;

    word_t result;

    always_comb begin
        case (exec_op)
            op_add:  result = exec_a + exec_b;
            op_sub:  result = exec_a - exec_b;
            op_and:  result = exec_a & exec_b;
            op_or:   result = exec_a | exec_b;
            op_xor:  result = exec_a ^ exec_b;
            op_sll:  result = exec_a << exec_b[4:0]; // low 5 bits only
            default: result = '0;
        endcase
    end

    // one cycle to the bus
    always_ff @(posedge clock) begin
        if (reset) begin
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid <= exec_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (exec_valid) begin
            cdb.tag     <= exec_tag;
            cdb.rob_idx <= exec_rob_idx;
            cdb.value   <= (exec_tag == '0) ? '0 : result; // tag 0 means rd r0
        end
    end

endmodule

// File: src/cdb_if.sv
// cdb_if result broadcast bus, dispatch_if rename to issue and rob
`timescale 1ns/1ps

interface cdb_if #(
    parameter int pr_count  = 48,
    parameter int rob_depth = 8
);
    import core_pkg::*;

    logic                         valid;   // one pulse per result
    logic [$clog2(pr_count)-1:0]  tag;     // physical dest tag
    logic [$clog2(rob_depth)-1:0] rob_idx; // entry to mark complete
    word_t                        value;

    modport source (output valid, tag, rob_idx, value);
    modport sink   (input  valid, tag, rob_idx, value);
endinterface

interface dispatch_if #(
    parameter int pr_count  = 48,
    parameter int rob_depth = 8
);
    import core_pkg::*;

    logic                         valid;      // allocation final when high
    alu_op_t                      op;
    word_t                        imm;
    logic                         use_imm;
    logic [$clog2(pr_count)-1:0]  src1_tag;
    logic [$clog2(pr_count)-1:0]  src2_tag;
    logic                         src1_ready;
    logic                         src2_ready;
    logic [$clog2(pr_count)-1:0]  dest_tag;   // 0 for rd == r0
    arch_reg_t                    rd;
    logic [$clog2(pr_count)-1:0]  old_tag;    // previous mapping of rd
    logic [$clog2(rob_depth)-1:0] rob_idx;

    modport source (output valid, op, imm, use_imm, src1_tag, src2_tag, src1_ready,
                    src2_ready, dest_tag, rd, old_tag, rob_idx);
    modport sink   (input  valid, op, imm, use_imm, src1_tag, src2_tag, src1_ready,
                    src2_ready, dest_tag, rd, old_tag, rob_idx);
endinterface

// File: src/core_pkg.sv
// core_pkg: data word, register index, alu op encoding, instruction struct
package core_pkg;

    ////////////////////////////////////////////////////////////////////////
    // basic types
    ////////////////////////////////////////////////////////////////////////

    typedef logic [31:0] word_t;     // one data word
    typedef logic [4:0]  arch_reg_t; // architectural register index

    localparam int arch_regs = 32;   // r0..r31, r0 reads as zero

    // alu operations
    // shift amount is the low 5 bits of the second operand
    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_and = 3'd2,
        op_or  = 3'd3,
        op_xor = 3'd4,
        op_sll = 3'd5
    } alu_op_t;

    ////////////////////////////////////////////////////////////////////////
    // instruction as it arrives at the core
    ////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        alu_op_t   op;
        arch_reg_t rd;
        arch_reg_t rs1;
        arch_reg_t rs2;
        word_t     imm;     // replaces rs2 when use_imm set
        logic      use_imm;
    } inst_t;

endpackage

// File: src/core_top.sv
// core_top: stage instances, bus interfaces and outside ports of the core
`timescale 1ns/1ps

module core_top #(
    parameter int pr_count  = 48, // physical registers, at least 34
    parameter int rob_depth = 8   // power of two
) (
    input  logic                clock,
    input  logic                reset,
    input  logic                inst_valid,
    input  core_pkg::inst_t     inst,
    output logic                inst_stall,
    output logic                retire_valid,
    output core_pkg::arch_reg_t retire_rd,
    output core_pkg::word_t     retire_value
);
    import core_pkg::*;

    localparam int tag_w = $clog2(pr_count);
    localparam int idx_w = $clog2(rob_depth);

    // fetch side
    logic             held_valid;
    inst_t            held_inst;
    logic             dispatch_stall;

    // tags
    logic             free_valid;
    logic [tag_w-1:0] free_tag;
    logic             alloc;
    logic             release_valid;
    logic [tag_w-1:0] release_tag;

    // rob and issue status
    logic             rob_full;
    logic [idx_w-1:0] rob_tail;
    logic             issue_busy;

    // issue -> alu
    logic             exec_valid;
    alu_op_t          exec_op;
    word_t            exec_a;
    word_t            exec_b;
    logic [tag_w-1:0] exec_tag;
    logic [idx_w-1:0] exec_rob_idx;

    cdb_if      #(.pr_count(pr_count), .rob_depth(rob_depth)) cdb ();
    dispatch_if #(.pr_count(pr_count), .rob_depth(rob_depth)) dis ();

    //////////////////////////////////////////////////////////////////////
    // front end
    //////////////////////////////////////////////////////////////////////

    inst_buffer ib_0 (
        .clock(clock), .reset(reset),
        .inst_valid(inst_valid), .inst(inst), .inst_stall(inst_stall),
        .held_valid(held_valid), .held_inst(held_inst),
        .dispatch_stall(dispatch_stall)
    );

    rename_stage #(.pr_count(pr_count), .rob_depth(rob_depth)) rn_0 (
        .clock(clock), .reset(reset),
        .held_valid(held_valid), .held_inst(held_inst),
        .dispatch_stall(dispatch_stall),
        .free_valid(free_valid), .free_tag(free_tag), .alloc(alloc),
        .rob_full(rob_full), .rob_tail(rob_tail), .issue_busy(issue_busy),
        .dis(dis.source), .cdb(cdb.sink)
    );

    free_list #(.pr_count(pr_count)) fl_0 (
        .clock(clock), .reset(reset),
        .alloc(alloc), .free_valid(free_valid), .free_tag(free_tag),
        .release_valid(release_valid), .release_tag(release_tag)
    );

    //////////////////////////////////////////////////////////////////////
    // back end
    //////////////////////////////////////////////////////////////////////

    issue_stage #(.pr_count(pr_count), .rob_depth(rob_depth)) is_0 (
        .clock(clock), .reset(reset),
        .dis(dis.sink), .cdb(cdb.sink), .issue_busy(issue_busy),
        .exec_valid(exec_valid), .exec_op(exec_op), .exec_a(exec_a), .exec_b(exec_b),
        .exec_tag(exec_tag), .exec_rob_idx(exec_rob_idx)
    );

    alu_stage #(.pr_count(pr_count), .rob_depth(rob_depth)) alu_0 (
        .clock(clock), .reset(reset),
        .exec_valid(exec_valid), .exec_op(exec_op), .exec_a(exec_a), .exec_b(exec_b),
        .exec_tag(exec_tag), .exec_rob_idx(exec_rob_idx),
        .cdb(cdb.source)
    );

    reorder_buffer #(.pr_count(pr_count), .rob_depth(rob_depth)) rob_0 (
        .clock(clock), .reset(reset),
        .dis(dis.sink), .cdb(cdb.sink),
        .rob_full(rob_full), .rob_tail(rob_tail),
        .release_valid(release_valid), .release_tag(release_tag),
        .retire_valid(retire_valid), .retire_rd(retire_rd), .retire_value(retire_value)
    );

endmodule

// File: src/free_list.sv
// free_list: circular buffer of free physical tags with occupancy count
`timescale 1ns/1ps

module free_list #(
    parameter int pr_count = 48
) (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        alloc,          // pop head
    output logic                        free_valid,
    output logic [$clog2(pr_count)-1:0] free_tag,
    input  logic                        release_valid,  // push at tail
    input  logic [$clog2(pr_count)-1:0] release_tag
);
    import core_pkg::*;

    localparam int tag_w   = $clog2(pr_count);
    localparam int fl_size = pr_count - arch_regs; // tags beyond the identity map
    localparam int ptr_w   = $clog2(fl_size);
    localparam int cnt_w   = $clog2(fl_size + 1);

    logic [tag_w-1:0] list [fl_size];
    logic [ptr_w-1:0] head, tail;
    logic [cnt_w-1:0] count;

    // wrap at fl_size, not always a power of two
    function automatic logic [ptr_w-1:0] step(input logic [ptr_w-1:0] p);
        return (p == ptr_w'(fl_size - 1)) ? '0 : p + 1'b1;
    endfunction

    assign free_valid = count != '0;
    assign free_tag   = list[head];

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;  // full, so tail sits on head
            count <= cnt_w'(fl_size);
            for (int i = 0; i < fl_size; i++) begin
                list[i] <= tag_w'(arch_regs + i);
            end
        end else begin
            if (release_valid) begin
                list[tail] <= release_tag;
                tail       <= step(tail);
            end
            if (alloc) begin
                head <= step(head);
            end
            count <= count + cnt_w'(release_valid) - cnt_w'(alloc);
        end
    end

endmodule

// File: src/inst_buffer.sv
// inst_buffer: one-entry holding register between the outside and dispatch
`timescale 1ns/1ps

module inst_buffer (
    input  logic            clock,
    input  logic            reset,
    input  logic            inst_valid,
    input  core_pkg::inst_t inst,
    output logic            inst_stall,     // outside holds its instruction
    output logic            held_valid,
    output core_pkg::inst_t held_inst,
    input  logic            dispatch_stall  // level from rename
);
    logic take; // slot empty or leaving this cycle

    // full and stuck -> push back
    assign inst_stall = held_valid && dispatch_stall;
    assign take       = !inst_stall;

    // valid bit
    always_ff @(posedge clock) begin
        if (reset) begin
            held_valid <= 1'b0;
        end else if (take) begin
            held_valid <= inst_valid; // empty again when nothing offered
        end
    end

    // payload only moves when a new instruction is taken
    always_ff @(posedge clock) begin
        if (take && inst_valid) begin
            held_inst <= inst;
        end
    end

endmodule

// File: src/issue_stage.sv
// issue_stage: one-slot operand wait, physical register file, send to alu
`timescale 1ns/1ps

module issue_stage #(
    parameter int pr_count  = 48,
    parameter int rob_depth = 8
) (
    input  logic                         clock,
    input  logic                         reset,
    dispatch_if.sink                     dis,
    cdb_if.sink                          cdb,
    output logic                         issue_busy,
    output logic                         exec_valid,
    output core_pkg::alu_op_t            exec_op,
    output core_pkg::word_t              exec_a,
    output core_pkg::word_t              exec_b,
    output logic [$clog2(pr_count)-1:0]  exec_tag,
    output logic [$clog2(rob_depth)-1:0] exec_rob_idx
);
    import core_pkg::*;

    localparam int tag_w = $clog2(pr_count);
    localparam int idx_w = $clog2(rob_depth);

    word_t            prf [pr_count];  // physical register file
    logic             held;
    alu_op_t          op_q;
    word_t            imm_q;
    logic             use_imm_q;
    logic [tag_w-1:0] tag1_q, tag2_q, dest_q;
    logic [idx_w-1:0] rob_idx_q;
    logic             r1_q, r2_q;      // operand already in the prf
    logic             hit1, hit2;      // operand on the bus right now
    logic             send;
    word_t            a_val, b_val;

    assign issue_busy = held;
    assign hit1 = cdb.valid && cdb.tag == tag1_q;
    assign hit2 = cdb.valid && cdb.tag == tag2_q;
    assign send = held && (r1_q || hit1) && (r2_q || hit2);

    // ready flag -> prf, otherwise bypass from the bus
    assign a_val = r1_q ? prf[tag1_q] : cdb.value;
    assign b_val = use_imm_q ? imm_q : (r2_q ? prf[tag2_q] : cdb.value);

    //////////////////////////////////////////////////////////////////////
    // control and register file
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            held       <= 1'b0;
            exec_valid <= 1'b0;
            for (int i = 0; i < pr_count; i++) begin
                prf[i] <= '0;
            end
        end else begin
            exec_valid <= send;
            if (dis.valid) begin
                held <= 1'b1; // only offered while empty
            end else if (send) begin
                held <= 1'b0;
            end
            if (cdb.valid) begin
                prf[cdb.tag] <= cdb.value;
            end
        end
    end

    // captured instruction, flags follow the bus while waiting
    always_ff @(posedge clock) begin
        if (dis.valid) begin
            op_q      <= dis.op;
            imm_q     <= dis.imm;
            use_imm_q <= dis.use_imm;
            tag1_q    <= dis.src1_tag;
            tag2_q    <= dis.src2_tag;
            dest_q    <= dis.dest_tag;
            rob_idx_q <= dis.rob_idx;
            r1_q      <= dis.src1_ready;
            r2_q      <= dis.src2_ready;
        end else begin
            r1_q <= r1_q || hit1;
            r2_q <= r2_q || hit2;
        end
        if (send) begin
            exec_op      <= op_q;
            exec_a       <= a_val;
            exec_b       <= b_val;
            exec_tag     <= dest_q;
            exec_rob_idx <= rob_idx_q;
        end
    end

endmodule

// File: src/rename_stage.sv
// rename_stage: map table, per-tag ready bits, dispatch decision
`timescale 1ns/1ps

module rename_stage #(
    parameter int pr_count  = 48,
    parameter int rob_depth = 8
) (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         held_valid,
    input  core_pkg::inst_t              held_inst,
    output logic                         dispatch_stall,
    input  logic                         free_valid,
    input  logic [$clog2(pr_count)-1:0]  free_tag,
    output logic                         alloc,       // pop the free list
    input  logic                         rob_full,
    input  logic [$clog2(rob_depth)-1:0] rob_tail,
    input  logic                         issue_busy,
    dispatch_if.source                   dis,
    cdb_if.sink                          cdb
);
    import core_pkg::*;

    localparam int tag_w = $clog2(pr_count);

    logic [tag_w-1:0]    map_tbl [arch_regs]; // arch reg -> newest tag
    logic [pr_count-1:0] ready;               // value of tag is in the prf
    logic                need_tag;            // rd != r0
    logic                go;
    logic [tag_w-1:0]    tag1, tag2;
    logic                rdy1, rdy2;

    //////////////////////////////////////////////////////////////////////
    // dispatch decision
    //////////////////////////////////////////////////////////////////////

    assign need_tag       = held_inst.rd != '0;
    assign dispatch_stall = rob_full || issue_busy || (need_tag && !free_valid);
    assign go             = held_valid && !dispatch_stall;
    assign alloc          = go && need_tag;

    // source lookup, a result on the bus this cycle counts as ready
    assign tag1 = map_tbl[held_inst.rs1];
    assign tag2 = map_tbl[held_inst.rs2];
    assign rdy1 = ready[tag1] || (cdb.valid && cdb.tag == tag1);
    assign rdy2 = ready[tag2] || (cdb.valid && cdb.tag == tag2);

    assign dis.valid      = go;
    assign dis.op         = held_inst.op;
    assign dis.imm        = held_inst.imm;
    assign dis.use_imm    = held_inst.use_imm;
    assign dis.src1_tag   = tag1;
    assign dis.src2_tag   = tag2;
    assign dis.src1_ready = rdy1;
    assign dis.src2_ready = held_inst.use_imm || rdy2; // imm needs no wait
    assign dis.dest_tag   = need_tag ? free_tag : '0;  // r0 keeps tag 0
    assign dis.rd         = held_inst.rd;
    assign dis.old_tag    = need_tag ? map_tbl[held_inst.rd] : '0;
    assign dis.rob_idx    = rob_tail;

    //////////////////////////////////////////////////////////////////////
    // map and readiness update
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < arch_regs; i++) begin
                map_tbl[i] <= tag_w'(i); // identity mapping
            end
            ready <= '1;
        end else begin
            if (cdb.valid) begin
                ready[cdb.tag] <= 1'b1;
            end
            // never the same tag as the bus, a free tag has no result in flight
            if (alloc) begin
                map_tbl[held_inst.rd] <= free_tag;
                ready[free_tag]       <= 1'b0;
            end
        end
    end

endmodule

// File: src/reorder_buffer.sv
// reorder_buffer: in-order completion tracking, retirement, tag release
`timescale 1ns/1ps

module reorder_buffer #(
    parameter int pr_count  = 48,
    parameter int rob_depth = 8
) (
    input  logic                         clock,
    input  logic                         reset,
    dispatch_if.sink                     dis,
    cdb_if.sink                          cdb,
    output logic                         rob_full,
    output logic [$clog2(rob_depth)-1:0] rob_tail,
    output logic                         release_valid,
    output logic [$clog2(pr_count)-1:0]  release_tag,
    output logic                         retire_valid,
    output core_pkg::arch_reg_t          retire_rd,
    output core_pkg::word_t              retire_value
);
    import core_pkg::*;

    localparam int tag_w = $clog2(pr_count);
    localparam int idx_w = $clog2(rob_depth);

    // entry fields
    arch_reg_t            rd_q    [rob_depth];
    logic [tag_w-1:0]     old_q   [rob_depth];
    word_t                value_q [rob_depth];
    logic [rob_depth-1:0] complete;

    logic [idx_w-1:0] head, tail;
    logic [idx_w:0]   count;
    logic             retire_go;

    assign rob_full  = count == (idx_w + 1)'(rob_depth);
    assign rob_tail  = tail;
    assign retire_go = (count != '0) && complete[head];

    //////////////////////////////////////////////////////////////////////
    // pointers and status
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            head          <= '0;
            tail          <= '0;
            count         <= '0;
            complete      <= '0;
            retire_valid  <= 1'b0;
            release_valid <= 1'b0;
        end else begin
            retire_valid  <= retire_go;
            release_valid <= retire_go && (old_q[head] != '0); // tag 0 is r0 only
            if (dis.valid) begin
                complete[tail] <= 1'b0;
                tail           <= tail + 1'b1;
            end
            if (cdb.valid) begin
                complete[cdb.rob_idx] <= 1'b1;
            end
            if (retire_go) begin
                head <= head + 1'b1;
            end
            count <= count + (idx_w + 1)'(dis.valid) - (idx_w + 1)'(retire_go);
        end
    end

    // payload
    always_ff @(posedge clock) begin
        if (dis.valid) begin
            rd_q[tail]  <= dis.rd;
            old_q[tail] <= dis.old_tag;
        end
        if (cdb.valid) begin
            value_q[cdb.rob_idx] <= cdb.value;
        end
        if (retire_go) begin
            retire_rd    <= rd_q[head];
            retire_value <= value_q[head];
            release_tag  <= old_q[head];
        end
    end

endmodule
